//--- rtl/rib_bus_pkg.sv
// ----------------------------------------------------------------------
// rib bus package: bus widths, signal types and port counts
// ----------------------------------------------------------------------

package rib_bus_pkg;

    // bus field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // number of ports on the interconnect
    localparam int MASTER_NUM = 3;
    localparam int SLAVE_NUM  = 2;

    // full bus address as driven by a master
    typedef logic [ADDR_W-1:0] rib_addr_t;

    // read and write data word
    typedef logic [DATA_W-1:0] rib_data_t;

    // one enable per byte lane
    typedef logic [SEL_W-1:0] rib_sel_t;

    // one bit per master, bit 0 is master 0
    typedef logic [MASTER_NUM-1:0] rib_mst_vec_t;

endpackage

//--- rtl/rib_map_pkg.sv
// ----------------------------------------------------------------------
// rib address map: slave index field, offset field and slave bases
// ----------------------------------------------------------------------

package rib_map_pkg;

    // top nibble of the address picks the slave
    localparam int SLV_IDX_MSB = 31;
    localparam int SLV_IDX_LSB = 28;
    localparam int SLV_IDX_W   = SLV_IDX_MSB - SLV_IDX_LSB + 1;

    // what is left is the offset seen by the slave
    localparam int OFFSET_W = SLV_IDX_LSB;

    // slave index as carried in the address
    typedef logic [SLV_IDX_W-1:0] rib_slv_idx_t;

    // address inside one slave
    typedef logic [OFFSET_W-1:0] rib_offset_t;

    // one bit per slave, bit 0 is slave 0
    typedef logic [rib_bus_pkg::SLAVE_NUM-1:0] rib_slv_vec_t;

    // base address of each slave window
    // only the index field of a base is compared by the decoder
    localparam rib_bus_pkg::rib_addr_t SLV_BASE [rib_bus_pkg::SLAVE_NUM] = '{
        32'h0000_0000,
        32'h1000_0000
    };

    // indices 2 to 15 are unmapped and select no slave

endpackage

//--- rtl/rib_bus_if.sv
// ----------------------------------------------------------------------
// rib channel: request and response handshake between two bus ports
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface rib_bus_if;

    import rib_bus_pkg::*;

    // request side, driven by whoever issues the transfer
    rib_addr_t addr;
    rib_data_t wdata;
    rib_sel_t  sel;
    logic      we;
    logic      req_vld;
    logic      rsp_rdy;

    // response side, driven by whoever serves the transfer
    logic      req_rdy;
    logic      rsp_vld;
    rib_data_t rdata;

    // request issuer
    modport master (
        output addr,
        output wdata,
        output sel,
        output we,
        output req_vld,
        output rsp_rdy,
        input  req_rdy,
        input  rsp_vld,
        input  rdata
    );

    // request server
    modport slave (
        input  addr,
        input  wdata,
        input  sel,
        input  we,
        input  req_vld,
        input  rsp_rdy,
        output req_rdy,
        output rsp_vld,
        output rdata
    );

endinterface

//--- rtl/rib_arbiter.sv
// ----------------------------------------------------------------------
// rib arbiter: fixed-priority grant, master mux and response return
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rib_arbiter (
    input logic       clk,
    input logic       rst_i,
    rib_bus_if.slave  m_bus_i [rib_bus_pkg::MASTER_NUM],
    rib_bus_if.master shared_bus_o
);

    import rib_bus_pkg::*;

    rib_mst_vec_t req;
    rib_mst_vec_t grant;
    rib_mst_vec_t m_we;
    rib_mst_vec_t m_rsp_rdy;
    rib_addr_t    m_addr  [MASTER_NUM];
    rib_data_t    m_wdata [MASTER_NUM];
    rib_sel_t     m_sel   [MASTER_NUM];

    rib_addr_t    mux_addr;
    rib_data_t    mux_wdata;
    rib_sel_t     mux_sel;
    logic         mux_we;
    logic         mux_req_vld;
    logic         mux_rsp_rdy;

    genvar k;

    // master channels as flat vectors for the mux
    for (k = 0; k < MASTER_NUM; k++) begin : g_mst
        assign req[k]       = m_bus_i[k].req_vld;
        assign m_we[k]      = m_bus_i[k].we;
        assign m_rsp_rdy[k] = m_bus_i[k].rsp_rdy;
        assign m_addr[k]    = m_bus_i[k].addr;
        assign m_wdata[k]   = m_bus_i[k].wdata;
        assign m_sel[k]     = m_bus_i[k].sel;

        // only the granted master sees the slave side
        assign m_bus_i[k].req_rdy = grant[k] & shared_bus_o.req_rdy;
        assign m_bus_i[k].rsp_vld = grant[k] & shared_bus_o.rsp_vld;
        assign m_bus_i[k].rdata   = {DATA_W{grant[k]}} & shared_bus_o.rdata;
    end

    // the lowest set request bit wins
    assign grant = req & (~req + 1'b1);

    // and-or mux of the granted request
    always_comb begin
        mux_addr    = '0;
        mux_wdata   = '0;
        mux_sel     = '0;
        mux_we      = 1'b0;
        mux_req_vld = 1'b0;
        mux_rsp_rdy = 1'b0;
        for (int i = 0; i < MASTER_NUM; i++) begin
            mux_addr    = mux_addr    | ({ADDR_W{grant[i]}} & m_addr[i]);
            mux_wdata   = mux_wdata   | ({DATA_W{grant[i]}} & m_wdata[i]);
            mux_sel     = mux_sel     | ({SEL_W{grant[i]}} & m_sel[i]);
            mux_we      = mux_we      | (grant[i] & m_we[i]);
            mux_req_vld = mux_req_vld | (grant[i] & req[i]);
            mux_rsp_rdy = mux_rsp_rdy | (grant[i] & m_rsp_rdy[i]);
        end
    end

    assign shared_bus_o.addr    = mux_addr;
    assign shared_bus_o.wdata   = mux_wdata;
    assign shared_bus_o.sel     = mux_sel;
    assign shared_bus_o.we      = mux_we;
    assign shared_bus_o.req_vld = mux_req_vld;
    assign shared_bus_o.rsp_rdy = mux_rsp_rdy;

    // at most one owner and always one when a master asks
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(grant) && ((|req) == (|grant))
    );

endmodule

//--- rtl/rib_decoder.sv
// ----------------------------------------------------------------------
// rib decoder: slave select, offset stripping, fan-out and response mux
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rib_decoder (
    input logic       clk,
    input logic       rst_i,
    rib_bus_if.slave  shared_bus_i,
    rib_bus_if.master s_bus_o [rib_bus_pkg::SLAVE_NUM]
);

    import rib_bus_pkg::*;
    import rib_map_pkg::*;

    rib_slv_idx_t idx;
    rib_offset_t  offset;
    rib_addr_t    strip_addr;
    rib_slv_vec_t slv_sel;

    rib_slv_vec_t s_req_rdy;
    rib_slv_vec_t s_rsp_vld;
    rib_data_t    s_rdata [SLAVE_NUM];

    // observed slave outputs, for the checks below
    rib_slv_vec_t s_req_vld_obs;
    rib_slv_vec_t s_idx_nz;

    rib_data_t    mux_rdata;
    logic         mux_req_rdy;
    logic         mux_rsp_vld;

    genvar n;

    assign idx    = shared_bus_i.addr[SLV_IDX_MSB:SLV_IDX_LSB];
    assign offset = shared_bus_i.addr[SLV_IDX_LSB-1:0];

    // slave sees its own offset only
    assign strip_addr = {{SLV_IDX_W{1'b0}}, offset};

    for (n = 0; n < SLAVE_NUM; n++) begin : g_slv
        // unmapped indices leave every select bit low
        assign slv_sel[n] = (idx == SLV_BASE[n][SLV_IDX_MSB:SLV_IDX_LSB]);

        // unselected slaves get all zeros
        assign s_bus_o[n].addr    = {ADDR_W{slv_sel[n]}} & strip_addr;
        assign s_bus_o[n].wdata   = {DATA_W{slv_sel[n]}} & shared_bus_i.wdata;
        assign s_bus_o[n].sel     = {SEL_W{slv_sel[n]}} & shared_bus_i.sel;
        assign s_bus_o[n].we      = slv_sel[n] & shared_bus_i.we;
        assign s_bus_o[n].req_vld = slv_sel[n] & shared_bus_i.req_vld;
        assign s_bus_o[n].rsp_rdy = slv_sel[n] & shared_bus_i.rsp_rdy;

        assign s_req_rdy[n] = s_bus_o[n].req_rdy;
        assign s_rsp_vld[n] = s_bus_o[n].rsp_vld;
        assign s_rdata[n]   = s_bus_o[n].rdata;

        assign s_req_vld_obs[n] = s_bus_o[n].req_vld;
        assign s_idx_nz[n]      = |s_bus_o[n].addr[SLV_IDX_MSB:SLV_IDX_LSB];
    end

    // pick the selected slave's response
    always_comb begin
        mux_rdata   = '0;
        mux_req_rdy = 1'b0;
        mux_rsp_vld = 1'b0;
        for (int i = 0; i < SLAVE_NUM; i++) begin
            mux_rdata   = mux_rdata   | ({DATA_W{slv_sel[i]}} & s_rdata[i]);
            mux_req_rdy = mux_req_rdy | (slv_sel[i] & s_req_rdy[i]);
            mux_rsp_vld = mux_rsp_vld | (slv_sel[i] & s_rsp_vld[i]);
        end
    end

    assign shared_bus_i.rdata   = mux_rdata;
    assign shared_bus_i.req_rdy = mux_req_rdy;
    assign shared_bus_i.rsp_vld = mux_rsp_vld;

    // two slaves must never see the same transfer
    a_one_slave: assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(s_req_vld_obs)
    );

    // base bits never leak past the decoder
    a_offset_only: assert property (
        @(posedge clk) disable iff (rst_i)
        s_idx_nz == '0
    );

endmodule

//--- rtl/rib_top.sv
// ----------------------------------------------------------------------
// rib interconnect top: three masters, two slaves, combinational paths
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rib_top (
    input  logic                   clk,
    input  logic                   rst_i,

    // master 0
    input  rib_bus_pkg::rib_addr_t m0_addr_i,
    input  rib_bus_pkg::rib_data_t m0_data_i,
    input  rib_bus_pkg::rib_sel_t  m0_sel_i,
    input  logic                   m0_we_i,
    input  logic                   m0_req_vld_i,
    input  logic                   m0_rsp_rdy_i,
    output logic                   m0_req_rdy_o,
    output logic                   m0_rsp_vld_o,
    output rib_bus_pkg::rib_data_t m0_data_o,

    // master 1
    input  rib_bus_pkg::rib_addr_t m1_addr_i,
    input  rib_bus_pkg::rib_data_t m1_data_i,
    input  rib_bus_pkg::rib_sel_t  m1_sel_i,
    input  logic                   m1_we_i,
    input  logic                   m1_req_vld_i,
    input  logic                   m1_rsp_rdy_i,
    output logic                   m1_req_rdy_o,
    output logic                   m1_rsp_vld_o,
    output rib_bus_pkg::rib_data_t m1_data_o,

    // master 2
    input  rib_bus_pkg::rib_addr_t m2_addr_i,
    input  rib_bus_pkg::rib_data_t m2_data_i,
    input  rib_bus_pkg::rib_sel_t  m2_sel_i,
    input  logic                   m2_we_i,
    input  logic                   m2_req_vld_i,
    input  logic                   m2_rsp_rdy_i,
    output logic                   m2_req_rdy_o,
    output logic                   m2_rsp_vld_o,
    output rib_bus_pkg::rib_data_t m2_data_o,

    // slave 0
    output rib_bus_pkg::rib_addr_t s0_addr_o,
    output rib_bus_pkg::rib_data_t s0_data_o,
    output rib_bus_pkg::rib_sel_t  s0_sel_o,
    output logic                   s0_we_o,
    output logic                   s0_req_vld_o,
    output logic                   s0_rsp_rdy_o,
    input  rib_bus_pkg::rib_data_t s0_data_i,
    input  logic                   s0_req_rdy_i,
    input  logic                   s0_rsp_vld_i,

    // slave 1
    output rib_bus_pkg::rib_addr_t s1_addr_o,
    output rib_bus_pkg::rib_data_t s1_data_o,
    output rib_bus_pkg::rib_sel_t  s1_sel_o,
    output logic                   s1_we_o,
    output logic                   s1_req_vld_o,
    output logic                   s1_rsp_rdy_o,
    input  rib_bus_pkg::rib_data_t s1_data_i,
    input  logic                   s1_req_rdy_i,
    input  logic                   s1_rsp_vld_i
);

    import rib_bus_pkg::*;

    rib_bus_if m_bus [MASTER_NUM] ();
    rib_bus_if shared_bus ();
    rib_bus_if s_bus [SLAVE_NUM] ();

    // master ports onto the master channels
    assign m_bus[0].addr    = m0_addr_i;
    assign m_bus[0].wdata   = m0_data_i;
    assign m_bus[0].sel     = m0_sel_i;
    assign m_bus[0].we      = m0_we_i;
    assign m_bus[0].req_vld = m0_req_vld_i;
    assign m_bus[0].rsp_rdy = m0_rsp_rdy_i;
    assign m0_req_rdy_o     = m_bus[0].req_rdy;
    assign m0_rsp_vld_o     = m_bus[0].rsp_vld;
    assign m0_data_o        = m_bus[0].rdata;

    assign m_bus[1].addr    = m1_addr_i;
    assign m_bus[1].wdata   = m1_data_i;
    assign m_bus[1].sel     = m1_sel_i;
    assign m_bus[1].we      = m1_we_i;
    assign m_bus[1].req_vld = m1_req_vld_i;
    assign m_bus[1].rsp_rdy = m1_rsp_rdy_i;
    assign m1_req_rdy_o     = m_bus[1].req_rdy;
    assign m1_rsp_vld_o     = m_bus[1].rsp_vld;
    assign m1_data_o        = m_bus[1].rdata;

    assign m_bus[2].addr    = m2_addr_i;
    assign m_bus[2].wdata   = m2_data_i;
    assign m_bus[2].sel     = m2_sel_i;
    assign m_bus[2].we      = m2_we_i;
    assign m_bus[2].req_vld = m2_req_vld_i;
    assign m_bus[2].rsp_rdy = m2_rsp_rdy_i;
    assign m2_req_rdy_o     = m_bus[2].req_rdy;
    assign m2_rsp_vld_o     = m_bus[2].rsp_vld;
    assign m2_data_o        = m_bus[2].rdata;

    // slave channels out to the slave ports
    assign s0_addr_o        = s_bus[0].addr;
    assign s0_data_o        = s_bus[0].wdata;
    assign s0_sel_o         = s_bus[0].sel;
    assign s0_we_o          = s_bus[0].we;
    assign s0_req_vld_o     = s_bus[0].req_vld;
    assign s0_rsp_rdy_o     = s_bus[0].rsp_rdy;
    assign s_bus[0].rdata   = s0_data_i;
    assign s_bus[0].req_rdy = s0_req_rdy_i;
    assign s_bus[0].rsp_vld = s0_rsp_vld_i;

    assign s1_addr_o        = s_bus[1].addr;
    assign s1_data_o        = s_bus[1].wdata;
    assign s1_sel_o         = s_bus[1].sel;
    assign s1_we_o          = s_bus[1].we;
    assign s1_req_vld_o     = s_bus[1].req_vld;
    assign s1_rsp_rdy_o     = s_bus[1].rsp_rdy;
    assign s_bus[1].rdata   = s1_data_i;
    assign s_bus[1].req_rdy = s1_req_rdy_i;
    assign s_bus[1].rsp_vld = s1_rsp_vld_i;

    rib_arbiter u_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .m_bus_i      (m_bus),
        .shared_bus_o (shared_bus)
    );

    rib_decoder u_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .shared_bus_i (shared_bus),
        .s_bus_o      (s_bus)
    );

endmodule

//--- sim/rib_slave_model.sv
// ----------------------------------------------------------------------
// rib slave model: word memory, optional random ready, same-cycle reply
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rib_slave_model #(
    parameter logic [31:0] SEED = 32'h0,
    parameter logic [31:0] FILL = 32'h0
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   rand_rdy_i,
    input  rib_bus_pkg::rib_addr_t addr_i,
    input  rib_bus_pkg::rib_data_t wdata_i,
    input  rib_bus_pkg::rib_sel_t  sel_i,
    input  logic                   we_i,
    input  logic                   req_vld_i,
    output logic                   req_rdy_o,
    output logic                   rsp_vld_o,
    output rib_bus_pkg::rib_data_t rdata_o
);

    import rib_bus_pkg::*;

    rib_data_t   mem [256];
    logic [7:0]  widx;
    logic        rnd_rdy;
    logic [31:0] rnd;
    int          seed;

    assign widx = addr_i[9:2];

    // start contents depend on the whole word index
    initial begin
        seed = SEED;
        for (int i = 0; i < 256; i++) begin
            mem[i] = FILL ^ (32'(i) * 32'h0101_0101);
        end
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        if (rst_i) begin
            rnd_rdy <= 1'b0;
        end else begin
            rnd_rdy <= rnd[4];
        end
    end

    assign req_rdy_o = rand_rdy_i ? rnd_rdy : 1'b1;

    // reply in the cycle the request is taken
    assign rsp_vld_o = req_vld_i & req_rdy_o;
    assign rdata_o   = rsp_vld_o ? mem[widx] : '0;

    // only the enabled byte lanes change
    always @(posedge clk) begin
        if (req_vld_i && req_rdy_o && we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- sim/tb_rib.sv
// ----------------------------------------------------------------------
// rib testbench: three masters, two memory slaves, checked every cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_rib;

    import rib_bus_pkg::*;
    import rib_map_pkg::*;

    localparam int          TIMEOUT = 200;
    localparam int          DEPTH   = 256;
    localparam logic [31:0] SEED    = 32'hb397bd6d;
    localparam rib_data_t   FILL0   = 32'h1234_0000;
    localparam rib_data_t   FILL1   = 32'h8765_ffff;

    logic clk;
    logic rst_i;
    logic rand_rdy;
    int   seed;

    rib_addr_t    m_addr  [MASTER_NUM];
    rib_data_t    m_wdata [MASTER_NUM];
    rib_sel_t     m_sel   [MASTER_NUM];
    rib_data_t    m_rdata [MASTER_NUM];
    rib_mst_vec_t m_we;
    rib_mst_vec_t m_req_vld;
    rib_mst_vec_t m_rsp_rdy;
    rib_mst_vec_t m_req_rdy;
    rib_mst_vec_t m_rsp_vld;

    rib_addr_t    s_addr  [SLAVE_NUM];
    rib_data_t    s_wdata [SLAVE_NUM];
    rib_sel_t     s_sel   [SLAVE_NUM];
    rib_data_t    s_rdata [SLAVE_NUM];
    rib_slv_vec_t s_we;
    rib_slv_vec_t s_req_vld;
    rib_slv_vec_t s_rsp_rdy;
    rib_slv_vec_t s_req_rdy;
    rib_slv_vec_t s_rsp_vld;

    // what each slave memory should hold
    rib_data_t    shadow [SLAVE_NUM][DEPTH];

    rib_top u_rib_top (
        .clk(clk), .rst_i(rst_i),
        .m0_addr_i(m_addr[0]), .m0_data_i(m_wdata[0]), .m0_sel_i(m_sel[0]), .m0_we_i(m_we[0]),
        .m0_req_vld_i(m_req_vld[0]), .m0_rsp_rdy_i(m_rsp_rdy[0]), .m0_req_rdy_o(m_req_rdy[0]),
        .m0_rsp_vld_o(m_rsp_vld[0]), .m0_data_o(m_rdata[0]),
        .m1_addr_i(m_addr[1]), .m1_data_i(m_wdata[1]), .m1_sel_i(m_sel[1]), .m1_we_i(m_we[1]),
        .m1_req_vld_i(m_req_vld[1]), .m1_rsp_rdy_i(m_rsp_rdy[1]), .m1_req_rdy_o(m_req_rdy[1]),
        .m1_rsp_vld_o(m_rsp_vld[1]), .m1_data_o(m_rdata[1]),
        .m2_addr_i(m_addr[2]), .m2_data_i(m_wdata[2]), .m2_sel_i(m_sel[2]), .m2_we_i(m_we[2]),
        .m2_req_vld_i(m_req_vld[2]), .m2_rsp_rdy_i(m_rsp_rdy[2]), .m2_req_rdy_o(m_req_rdy[2]),
        .m2_rsp_vld_o(m_rsp_vld[2]), .m2_data_o(m_rdata[2]),
        .s0_addr_o(s_addr[0]), .s0_data_o(s_wdata[0]), .s0_sel_o(s_sel[0]), .s0_we_o(s_we[0]),
        .s0_req_vld_o(s_req_vld[0]), .s0_rsp_rdy_o(s_rsp_rdy[0]), .s0_data_i(s_rdata[0]),
        .s0_req_rdy_i(s_req_rdy[0]), .s0_rsp_vld_i(s_rsp_vld[0]),
        .s1_addr_o(s_addr[1]), .s1_data_o(s_wdata[1]), .s1_sel_o(s_sel[1]), .s1_we_o(s_we[1]),
        .s1_req_vld_o(s_req_vld[1]), .s1_rsp_rdy_o(s_rsp_rdy[1]), .s1_data_i(s_rdata[1]),
        .s1_req_rdy_i(s_req_rdy[1]), .s1_rsp_vld_i(s_rsp_vld[1])
    );

    rib_slave_model #(.SEED(SEED), .FILL(FILL0)) u_slave0 (
        .clk(clk), .rst_i(rst_i), .rand_rdy_i(rand_rdy),
        .addr_i(s_addr[0]), .wdata_i(s_wdata[0]), .sel_i(s_sel[0]), .we_i(s_we[0]),
        .req_vld_i(s_req_vld[0]),
        .req_rdy_o(s_req_rdy[0]), .rsp_vld_o(s_rsp_vld[0]), .rdata_o(s_rdata[0])
    );

    rib_slave_model #(.SEED(SEED + 32'd1), .FILL(FILL1)) u_slave1 (
        .clk(clk), .rst_i(rst_i), .rand_rdy_i(rand_rdy),
        .addr_i(s_addr[1]), .wdata_i(s_wdata[1]), .sel_i(s_sel[1]), .we_i(s_we[1]),
        .req_vld_i(s_req_vld[1]),
        .req_rdy_o(s_req_rdy[1]), .rsp_vld_o(s_rsp_vld[1]), .rdata_o(s_rdata[1])
    );

    always #2 clk = ~clk;

    // old word with the enabled lanes of the new word laid over it
    function automatic rib_data_t merge_bytes(input rib_data_t old_w, input rib_data_t new_w,
                                              input rib_sel_t sel);
        rib_data_t res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic rib_data_t exp_read(input int slv, input rib_offset_t offset,
                                           input rib_data_t mem [SLAVE_NUM][DEPTH]);
        return mem[slv][offset[9:2]];
    endfunction

    function automatic rib_addr_t word_addr(input int slv, input logic [7:0] idx);
        return SLV_BASE[slv] | {22'h0, idx, 2'b00};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: at %0t ns, %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic set_req(input int m, input rib_addr_t addr, input logic we,
                           input rib_data_t wdata, input rib_sel_t sel);
        m_addr[m]    <= addr;
        m_wdata[m]   <= wdata;
        m_sel[m]     <= sel;
        m_we[m]      <= we;
        m_req_vld[m] <= 1'b1;
        m_rsp_rdy[m] <= 1'b1;
    endtask

    task automatic drop_req(input int m);
        @(posedge clk);
        m_req_vld[m] <= 1'b0;
        m_rsp_rdy[m] <= 1'b0;
        m_we[m]      <= 1'b0;
    endtask

    task automatic wait_rsp(input int m);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!m_rsp_vld[m]) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("master %0d got no response within %0d cycles", m, TIMEOUT);
                $display("Simulation finished: FAIL");
                $fatal(1, "response timeout");
            end
            @(negedge clk);
        end
    endtask

    // one complete transfer with the shadow updated after a write
    task automatic xfer(input int m, input rib_addr_t addr, input logic we,
                        input rib_data_t wdata, input rib_sel_t sel);
        int slv;
        slv = int'(addr[SLV_IDX_MSB:SLV_IDX_LSB]);
        @(posedge clk);
        set_req(m, addr, we, wdata, sel);
        wait_rsp(m);
        drop_req(m);
        if (we) begin
            shadow[slv][addr[9:2]] = merge_bytes(shadow[slv][addr[9:2]], wdata, sel);
        end
    endtask

    // expected interconnect behavior compared in the middle of every cycle
    always @(negedge clk) begin
        int        gnt;
        int        slv;
        logic      hit;
        rib_addr_t addr;
        rib_data_t gnt_wdata;
        rib_sel_t  gnt_sel;
        logic      gnt_we;
        logic      gnt_rsp_rdy;
        if (!rst_i) begin
            gnt = -1;
            for (int m = MASTER_NUM - 1; m >= 0; m--) begin
                if (m_req_vld[m]) begin
                    gnt = m;
                end
            end
            addr        = (gnt >= 0) ? m_addr[gnt] : '0;
            gnt_wdata   = (gnt >= 0) ? m_wdata[gnt] : '0;
            gnt_sel     = (gnt >= 0) ? m_sel[gnt] : '0;
            gnt_we      = (gnt >= 0) ? m_we[gnt] : 1'b0;
            gnt_rsp_rdy = (gnt >= 0) ? m_rsp_rdy[gnt] : 1'b0;
            slv  = (gnt >= 0) ? int'(addr[SLV_IDX_MSB:SLV_IDX_LSB]) : -1;
            for (int n = 0; n < SLAVE_NUM; n++) begin
                // an unselected slave sees all zeros
                hit = (slv == n);
                check_eq($sformatf("s%0d_req_vld_o", n), 32'(s_req_vld[n]), 32'(hit));
                check_eq($sformatf("s%0d_addr_o", n), s_addr[n],
                         hit ? {4'h0, addr[27:0]} : 32'h0);
                check_eq($sformatf("s%0d_data_o", n), s_wdata[n],
                         hit ? gnt_wdata : 32'h0);
                check_eq($sformatf("s%0d_sel_o", n), 32'(s_sel[n]),
                         hit ? 32'(gnt_sel) : 32'h0);
                check_eq($sformatf("s%0d_we_o", n), 32'(s_we[n]), 32'(hit & gnt_we));
                check_eq($sformatf("s%0d_rsp_rdy_o", n), 32'(s_rsp_rdy[n]),
                         32'(hit & gnt_rsp_rdy));
            end
            for (int m = 0; m < MASTER_NUM; m++) begin
                if (m != gnt || slv >= SLAVE_NUM) begin
                    check_eq($sformatf("m%0d_req_rdy_o", m), 32'(m_req_rdy[m]), 32'd0);
                    check_eq($sformatf("m%0d_rsp_vld_o", m), 32'(m_rsp_vld[m]), 32'd0);
                    check_eq($sformatf("m%0d_data_o", m), m_rdata[m], 32'h0);
                end else begin
                    // slave back-pressure reaches the granted master unchanged
                    check_eq($sformatf("m%0d_req_rdy_o", m), 32'(m_req_rdy[m]),
                             32'(s_req_rdy[slv]));
                    check_eq($sformatf("m%0d_rsp_vld_o", m), 32'(m_rsp_vld[m]),
                             32'(s_rsp_vld[slv]));
                    if (m_rsp_vld[m]) begin
                        // a response only for an accepted request
                        check_eq($sformatf("m%0d_req_rdy_o", m), 32'(m_req_rdy[m]), 32'd1);
                        if (!m_we[m]) begin
                            check_eq($sformatf("m%0d_data_o", m), m_rdata[m],
                                     exp_read(slv, addr[27:0], shadow));
                        end
                    end
                end
            end
        end
    end

    initial begin
        int          m;
        int          slv;
        logic [7:0]  idx;
        rib_sel_t    sel;
        logic        we;
        clk      = 1'b0;
        rst_i    = 1'b1;
        rand_rdy = 1'b0;
        seed     = SEED;
        m_we      = '0;
        m_req_vld = '0;
        m_rsp_rdy = '0;
        for (int k = 0; k < MASTER_NUM; k++) begin
            m_addr[k]  = '0;
            m_wdata[k] = '0;
            m_sel[k]   = '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            shadow[0][i] = FILL0 ^ (32'(i) * 32'h0101_0101);
            shadow[1][i] = FILL1 ^ (32'(i) * 32'h0101_0101);
        end
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // idle bus with every output low
        repeat (10) @(negedge clk);

        // full words into both slave windows and read back
        for (int i = 0; i < 8; i++) begin
            for (int n = 0; n < SLAVE_NUM; n++) begin
                xfer(0, word_addr(n, 8'(8'h10 + i)), 1'b1, $random(seed), 4'hf);
                xfer(0, word_addr(n, 8'(8'h10 + i)), 1'b0, '0, 4'hf);
            end
        end

        // partial writes
        for (int i = 0; i < 16; i++) begin
            idx = 8'($random(seed));
            sel = 4'($random(seed));
            xfer(0, word_addr(i % SLAVE_NUM, idx), 1'b1, $random(seed), sel);
            xfer(0, word_addr(i % SLAVE_NUM, idx), 1'b0, '0, 4'hf);
        end

        // three requests in one cycle served in master order
        @(posedge clk);
        for (int k = 0; k < MASTER_NUM; k++) begin
            set_req(k, word_addr(k % SLAVE_NUM, 8'(8'h40 + k)), 1'b0, '0, 4'hf);
        end
        for (int k = 0; k < MASTER_NUM; k++) begin
            wait_rsp(k);
            drop_req(k);
        end

        // random traffic under back-pressure
        rand_rdy <= 1'b1;
        for (int i = 0; i < 200; i++) begin
            m   = int'({$random(seed)} % 32'(MASTER_NUM));
            slv = int'({$random(seed)} % 32'(SLAVE_NUM));
            idx = 8'($random(seed));
            we  = 1'($random(seed));
            sel = we ? 4'($random(seed)) : 4'hf;
            xfer(m, word_addr(slv, idx), we, $random(seed), sel);
        end
        rand_rdy <= 1'b0;

        // unmapped window where nobody answers
        @(posedge clk);
        set_req(0, 32'h2000_0010, 1'b0, '0, 4'hf);
        repeat (20) @(negedge clk);
        check_eq("m0_rsp_vld_o", 32'(m_rsp_vld[0]), 32'd0);
        drop_req(0);
        repeat (4) @(negedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- rib.f
rtl/rib_bus_pkg.sv
rtl/rib_map_pkg.sv
rtl/rib_bus_if.sv
rtl/rib_arbiter.sv
rtl/rib_decoder.sv
rtl/rib_top.sv
sim/rib_slave_model.sv
sim/tb_rib.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the rib interconnect testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rib -f rib.f -o tb_rib \
    && ./obj_dir/tb_rib \
    && echo "run.sh: simulation exited cleanly" \
    || { echo "run.sh: build or simulation reported an error"; exit 1; }
